//--- run.sh
#!/bin/sh
# build and run the fetch unit testbench with verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
	--top-module fetch_unit_tb -f rv_fetch.f -o fetch_unit_tb
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/fetch_unit_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "CHECKS FAILED" "$log"; then
	exit 1
fi
exit 0

//--- rv_fetch.f
+incdir+verilog
verilog/rv_fetch_pkg.sv
verilog/branch_predecode.sv
verilog/pc_gen.sv
verilog/wb_fetch_master.sv
verilog/fetch_unit.sv
sim/wb_imem_model.sv
sim/fetch_unit_tb.sv

//--- sim/fetch_unit_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_fetch_params.svh"

module fetch_unit_tb;

	import rv_fetch_pkg::*;

	localparam int RESET_CYCLES = 10;
	localparam int N_SEQ = 8;
	localparam int N_RAND = 300;
	localparam int N_REDIR = 24;
	// about 12 cycles per packet and two packets per redirect
	localparam int CYCLE_LIMIT = (N_SEQ + N_RAND + 2 * N_REDIR) * 12 + RESET_CYCLES;
	localparam logic [1:0] K_NONE = 2'd0;
	localparam logic [1:0] K_COND = 2'd1;
	localparam logic [1:0] K_JAL = 2'd2;

	logic clk = 1'b0;
	logic rst_n;
	wb_m2s_t wb_o;
	wb_s2m_t wb_i;
	fetch_pkt_t pkt;
	logic pkt_valid;
	logic pkt_ready;
	logic redirect_valid;
	logic [`XLEN-1:0] redirect_pc;

	// program image by 32 bit slot indexed with pc bits 11:2
	logic [31:0] slot_inst [0:1023];
	logic [1:0] slot_kind [0:1023];
	logic [`XLEN-1:0] slot_off [0:1023];

	// reference model state
	integer seed;
	int errors = 0;
	int cycles = 0;
	int accepted = 0;
	int n_jal = 0;
	int n_taken = 0;
	int n_fall = 0;
	logic [`XLEN-1:0] exp_pc = `RESET_PC;
	logic waiting = 1'b0;
	logic was_valid = 1'b0;
	logic bus_wait = 1'b0;
	fetch_pkt_t held_pkt;
	wb_m2s_t held_bus;
	logic [`XLEN-1:0] last_adr = '0;
	logic prev_ack = 1'b0;
	logic prev_clean = 1'b0;
	logic prev_accept = 1'b0;
	logic draining = 1'b0;

	fetch_unit i_fetch_unit (
		.clk (clk),
		.rst_n (rst_n),
		.wb_o (wb_o),
		.wb_i (wb_i),
		.pkt (pkt),
		.pkt_valid (pkt_valid),
		.pkt_ready (pkt_ready),
		.redirect_valid (redirect_valid),
		.redirect_pc (redirect_pc)
	);

	wb_imem_model i_imem (
		.clk (clk),
		.rst_n (rst_n),
		.m2s (wb_o),
		.s2m (wb_i)
	);

	always #5 clk = ~clk;

	// run limit
	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, packet stream stalled", cycles);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	// *************************************************************************
	// instruction encoders and program image
	// *************************************************************************

	function automatic logic [31:0] enc_jal(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	function automatic logic [31:0] enc_branch(input logic [12:0] imm, input logic [2:0] f3,
			input logic [9:0] rs);
		return {imm[12], imm[10:5], rs[9:5], rs[4:0], f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	task automatic build_program();
		int i;
		int r;
		int step;
		int f3_idx;
		logic [31:0] word;
		for (i = 0; i < 1024; i++) begin
			r = {$random(seed)} % 8;
			word = $random(seed);
			slot_kind[i] = K_NONE;
			slot_off[i] = '0;
			if (i < N_SEQ || (r >= 3 && r <= 6)) begin
				// alu op as addi or add with random fields
				slot_inst[i] = {word[31:7], (word[0] ? 7'b0010011 : 7'b0110011)};
			end else if (r == 7) begin
				// branch opcode with funct3 010 or 011 is no branch
				slot_inst[i] = {word[31:15], 2'b01, word[12:7], 7'b1100011};
			end else if (r == 0) begin
				step = ({$random(seed)} % 64) - 32;
				if (step == 0) begin
					step = 1;
				end
				slot_kind[i] = K_JAL;
				slot_off[i] = 64'(step * 4);
				slot_inst[i] = enc_jal(slot_off[i][20:0], word[11:7]);
			end else begin
				step = ({$random(seed)} % 32) + 1;
				if (word[31]) begin
					step = -step;
				end
				f3_idx = {$random(seed)} % 6;
				slot_kind[i] = K_COND;
				slot_off[i] = 64'(step * 4);
				// 000 001 100 101 110 111
				slot_inst[i] = enc_branch(slot_off[i][12:0],
					3'(f3_idx < 2 ? f3_idx : f3_idx + 2), word[21:12]);
			end
		end
		for (i = 0; i < 512; i++) begin
			i_imem.write_word(i, {slot_inst[2 * i + 1], slot_inst[2 * i]});
		end
	endtask

	// *************************************************************************
	// checks and reference model
	// *************************************************************************

	task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
		assert (exp === act) else begin
			$display("ERR %s expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic observe_cycle();
		logic [9:0] s;
		logic exp_taken;
		logic [`XLEN-1:0] exp_target;
		// bus rules
		if (wb_o.cyc || wb_o.stb) begin
			// cyc and stb rise together
			check_val("wb_o.cyc", 64'h1, 64'(wb_o.cyc));
			check_val("wb_o.stb", 64'h1, 64'(wb_o.stb));
			check_val("wb_o.adr[2:0]", 64'h0, 64'(wb_o.adr[2:0]));
			check_val("wb_o.we", 64'h0, 64'(wb_o.we));
			check_val("wb_o.sel", 64'hff, 64'(wb_o.sel));
		end
		if (bus_wait) begin
			assert (wb_o.cyc && wb_o === held_bus) else begin
				$display("bus signals changed before ack in cycle %0d", cycles);
				errors++;
			end
		end
		// bus is released one cycle after ack
		if (prev_ack) begin
			check_val("wb_o.cyc", 64'h0, 64'(wb_o.cyc));
			// only a read without redirect gives a packet
			check_val("pkt_valid", 64'(prev_clean), 64'(pkt_valid));
		end
		// next read starts one cycle after an accept
		if (prev_accept) begin
			check_val("wb_o.cyc", 64'h1, 64'(wb_o.cyc));
		end
		bus_wait = wb_o.cyc && !wb_i.ack;
		held_bus = wb_o;
		prev_ack = wb_o.cyc && wb_i.ack;
		prev_clean = prev_ack && !redirect_valid && !draining;
		if (prev_ack) begin
			last_adr = wb_o.adr;
			draining = 1'b0;
		end else if (wb_o.cyc && redirect_valid) begin
			// read goes on but its data is dropped
			draining = 1'b1;
		end
		// packet stream
		if (redirect_valid) begin
			// packet of this cycle is wrong-path
			exp_pc = redirect_pc;
			waiting = 1'b0;
		end else if (pkt_valid) begin
			if (waiting) begin
				assert (pkt === held_pkt) else begin
					$display("packet changed while pkt_ready was low, cycle %0d", cycles);
					errors++;
				end
			end
			s = exp_pc[11:2];
			check_val("pkt.pc", exp_pc, pkt.pc);
			if (!was_valid) begin
				check_val("wb_o.adr", {exp_pc[63:3], 3'b000}, last_adr);
			end
			check_val("pkt.inst", 64'(slot_inst[s]), 64'(pkt.inst));
			exp_taken = slot_kind[s] == K_JAL || (slot_kind[s] == K_COND && slot_off[s][63]);
			exp_target = exp_taken ? exp_pc + slot_off[s] : exp_pc + 64'd4;
			check_val("pkt.pred_taken", 64'(exp_taken), 64'(pkt.pred_taken));
			check_val("pkt.pred_target", exp_target, pkt.pred_target);
			if (pkt_ready) begin
				accepted++;
				if (slot_kind[s] == K_JAL) begin
					n_jal++;
				end else if (slot_kind[s] == K_COND && exp_taken) begin
					n_taken++;
				end else if (slot_kind[s] == K_COND) begin
					n_fall++;
				end
				exp_pc = exp_target;
				waiting = 1'b0;
			end else begin
				waiting = 1'b1;
				held_pkt = pkt;
			end
		end else if (waiting) begin
			$display("packet dropped while waiting for pkt_ready, cycle %0d", cycles);
			errors++;
			waiting = 1'b0;
		end
		prev_accept = pkt_valid && pkt_ready && !redirect_valid;
		was_valid = pkt_valid;
	endtask

	// *************************************************************************
	// tests
	// *************************************************************************

	task automatic run_stream(input string name, input int n, input int ready_pct,
			input int redir_one_in);
		int start_err;
		int start_acc;
		start_err = errors;
		start_acc = accepted;
		while (accepted - start_acc < n) begin
			@(negedge clk);
			pkt_ready = ({$random(seed)} % 100) < ready_pct;
			redirect_valid = redir_one_in != 0 && ({$random(seed)} % redir_one_in) == 0;
			redirect_pc = {$random(seed), $random(seed)} & ~64'h3;
			#1;
			observe_cycle();
		end
		$display("test %s: %0d packets, %0d errors", name, accepted - start_acc,
			errors - start_err);
	endtask

	// redirect while a read waits for ack and then one packet from the new pc
	task automatic run_redirects(input string name, input int n);
		int start_err;
		int k;
		int target;
		logic fired;
		start_err = errors;
		for (k = 0; k < n; k++) begin
			fired = 1'b0;
			while (!fired) begin
				@(negedge clk);
				pkt_ready = 1'b1;
				fired = wb_o.cyc && !wb_i.ack;
				redirect_valid = fired;
				redirect_pc = {$random(seed), $random(seed)} & ~64'h3;
				#1;
				observe_cycle();
			end
			target = accepted + 1;
			while (accepted < target) begin
				@(negedge clk);
				redirect_valid = 1'b0;
				pkt_ready = ({$random(seed)} % 2) == 0;
				#1;
				observe_cycle();
			end
		end
		$display("test %s: %0d redirects, %0d errors", name, n, errors - start_err);
	endtask

	initial begin
		seed = 32'hacc8;
		rst_n = 1'b0;
		pkt_ready = 1'b0;
		redirect_valid = 1'b0;
		redirect_pc = '0;
		build_program();
		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1;
		run_stream("reset_sequential", N_SEQ, 100, 0);
		run_stream("random_stream", N_RAND, 70, 40);
		run_redirects("redirect_in_bus", N_REDIR);
		// every prediction class must have been seen
		assert (n_jal > 0 && n_taken > 0 && n_fall > 0) else begin
			$display("a branch class never reached an accepted packet");
			errors++;
		end
		$display("summary: %0d packets, %0d jal, %0d taken, %0d not taken, %0d errors",
			accepted, n_jal, n_taken, n_fall, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- sim/wb_imem_model.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_fetch_params.svh"

module wb_imem_model (
	input wire logic clk,
	input wire logic rst_n,
	input wire rv_fetch_pkg::wb_m2s_t m2s,
	output rv_fetch_pkg::wb_s2m_t s2m
);

	import rv_fetch_pkg::*;

	// 512 words, adr bits 11:3 pick one, everything else aliases
	logic [`XLEN-1:0] mem [0:511];
	logic busy;
	logic [1:0] wait_cnt;
	int unsigned gap;
	integer seed;

	initial begin
		seed = 32'hacc8;
	end

	// program load from the testbench
	task automatic write_word(input int idx, input logic [`XLEN-1:0] data);
		mem[idx[8:0]] = data;
	endtask

	// ack 1 to 4 cycles after stb is first seen
	always @(posedge clk) begin
		if (!rst_n) begin
			s2m.ack <= 1'b0;
			s2m.dat <= '0;
			busy <= 1'b0;
			wait_cnt <= '0;
		end else if (s2m.ack) begin
			// one cycle only, master drops stb next
			s2m.ack <= 1'b0;
		end else if (busy) begin
			if (wait_cnt == 2'd1) begin
				s2m.ack <= 1'b1;
				s2m.dat <= mem[m2s.adr[11:3]];
				busy <= 1'b0;
			end
			wait_cnt <= wait_cnt - 2'd1;
		end else if (m2s.cyc && m2s.stb) begin
			gap = {$random(seed)} % 4;
			if (gap == 0) begin
				s2m.ack <= 1'b1;
				s2m.dat <= mem[m2s.adr[11:3]];
			end else begin
				busy <= 1'b1;
				wait_cnt <= gap[1:0];
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/branch_predecode.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_fetch_params.svh"

module branch_predecode (
	input wire logic [`ILEN-1:0] inst,
	output rv_fetch_pkg::predecode_t pd
);

	import rv_fetch_pkg::*;

	// *************************************************************************
	// field extraction
	// *************************************************************************

	logic [6:0] opcode;
	logic [2:0] funct3;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];

	// *************************************************************************
	// immediates
	// *************************************************************************

	logic [`XLEN-1:0] imm_b;
	logic [`XLEN-1:0] imm_j;

	// B type, imm[12|10:5] in 31:25, imm[4:1|11] in 11:7
	// replication covers imm[12] as well as the sign
	assign imm_b = {
		{(`XLEN-12){inst[31]}},
		inst[7],
		inst[30:25],
		inst[11:8],
		1'b0
	};

	// J type, imm[20|10:1|11|19:12] in 31:12
	assign imm_j = {
		{(`XLEN-20){inst[31]}},
		inst[19:12],
		inst[20],
		inst[30:21],
		1'b0
	};

	// *************************************************************************
	// classification
	// *************************************************************************

	logic cond_f3;

	// funct3 010 and 011 are not branches
	always_comb begin
		case (funct3)
			`F3_BEQ, `F3_BNE, `F3_BLT, `F3_BGE, `F3_BLTU, `F3_BGEU: begin
				cond_f3 = 1'b1;
			end
			default: begin
				cond_f3 = 1'b0;
			end
		endcase
	end

	always_comb begin
		// default is a plain instruction
		pd.kind = br_none;
		pd.imm = '0;
		if (opcode == `OPC_JAL) begin
			pd.kind = br_jal;
			pd.imm = imm_j;
		end else if (opcode == `OPC_BRANCH && cond_f3) begin
			pd.kind = br_cond;
			pd.imm = imm_b;
		end
	end

endmodule

`default_nettype wire

//--- verilog/fetch_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_fetch_params.svh"

module fetch_unit (
	input wire logic clk,
	input wire logic rst_n,
	output rv_fetch_pkg::wb_m2s_t wb_o,
	input wire rv_fetch_pkg::wb_s2m_t wb_i,
	output rv_fetch_pkg::fetch_pkt_t pkt,
	output logic pkt_valid,
	input wire logic pkt_ready,
	input wire logic redirect_valid,
	input wire logic [`XLEN-1:0] redirect_pc
);

	import rv_fetch_pkg::*;

	// *************************************************************************
	// internal wires
	// *************************************************************************

	logic [`XLEN-1:0] pc;
	logic [`ILEN-1:0] inst;
	logic accept;
	predecode_t pd;
	pc_cmd_t cmd;
	logic pred_taken;
	logic [`XLEN-1:0] pred_target;

	// bus side, pc register and packet
	wb_fetch_master i_wb_fetch_master (
		.clk (clk),
		.rst_n (rst_n),
		.wb_o (wb_o),
		.wb_i (wb_i),
		.cmd (cmd),
		.pred_taken (pred_taken),
		.pred_target (pred_target),
		.pc (pc),
		.inst (inst),
		.accept (accept),
		.pkt (pkt),
		.pkt_valid (pkt_valid),
		.pkt_ready (pkt_ready)
	);

	// looks at the held instruction
	branch_predecode i_branch_predecode (
		.inst (inst),
		.pd (pd)
	);

	// prediction and next pc choice
	pc_gen i_pc_gen (
		.pc (pc),
		.pd (pd),
		.accept (accept),
		.redirect_valid (redirect_valid),
		.redirect_pc (redirect_pc),
		.pred_taken (pred_taken),
		.pred_target (pred_target),
		.cmd (cmd)
	);

endmodule

`default_nettype wire

//--- verilog/pc_gen.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_fetch_params.svh"

module pc_gen (
	input wire logic [`XLEN-1:0] pc,
	input wire rv_fetch_pkg::predecode_t pd,
	input wire logic accept,
	input wire logic redirect_valid,
	input wire logic [`XLEN-1:0] redirect_pc,
	output logic pred_taken,
	output logic [`XLEN-1:0] pred_target,
	output rv_fetch_pkg::pc_cmd_t cmd
);

	import rv_fetch_pkg::*;

	// *************************************************************************
	// static prediction
	// *************************************************************************

	logic [`XLEN-1:0] seq_pc;
	logic [`XLEN-1:0] br_pc;

	assign seq_pc = pc + `XLEN'(4);
	assign br_pc = pc + pd.imm;

	// jal always, backward conditional branches only
	assign pred_taken = (pd.kind == br_jal) || (pd.kind == br_cond && pd.imm[`XLEN-1]);

	assign pred_target = pred_taken ? br_pc : seq_pc;

	// *************************************************************************
	// next pc command
	// *************************************************************************

	always_comb begin
		// idle unless something moves the pc
		cmd.load = 1'b0;
		cmd.flush = 1'b0;
		cmd.pc = pred_target;
		if (redirect_valid) begin
			// redirect beats a same cycle accept
			cmd.load = 1'b1;
			cmd.flush = 1'b1;
			cmd.pc = redirect_pc;
		end else if (accept) begin
			// packet taken, follow the prediction
			cmd.load = 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- verilog/rv_fetch_params.svh
`ifndef RV_FETCH_PARAMS_SVH
`define RV_FETCH_PARAMS_SVH

// datapath and instruction widths
`define XLEN 64
`define ILEN 32
`define WB_SEL_W 8

// first fetch address out of reset
`define RESET_PC 64'h80000000

// major opcodes seen by the predecoder
`define OPC_JAL 7'b1101111
`define OPC_BRANCH 7'b1100011

// funct3 of the six conditional branches
`define F3_BEQ 3'b000
`define F3_BNE 3'b001
`define F3_BLT 3'b100
`define F3_BGE 3'b101
`define F3_BLTU 3'b110
`define F3_BGEU 3'b111

`endif

//--- verilog/rv_fetch_pkg.sv
`default_nettype none

`include "rv_fetch_params.svh"

package rv_fetch_pkg;

	// control transfer class of one instruction
	typedef enum logic [1:0] {
		br_none = 2'd0,
		br_cond = 2'd1,
		br_jal = 2'd2
	} br_kind_e;

	// predecoder result, imm is zero for br_none
	typedef struct packed {
		br_kind_e kind;
		logic [`XLEN-1:0] imm;
	} predecode_t;

	// packet handed to decode
	typedef struct packed {
		logic [`XLEN-1:0] pc;
		logic [`ILEN-1:0] inst;
		logic pred_taken;
		// next pc as predicted, pc + 4 when not taken
		logic [`XLEN-1:0] pred_target;
	} fetch_pkt_t;

	// pc update request from pc_gen
	typedef struct packed {
		logic load;
		logic flush;
		logic [`XLEN-1:0] pc;
	} pc_cmd_t;

	// wishbone classic, master to slave
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [`WB_SEL_W-1:0] sel;
		logic [`XLEN-1:0] adr;
	} wb_m2s_t;

	// wishbone classic, slave to master
	typedef struct packed {
		logic [`XLEN-1:0] dat;
		logic ack;
	} wb_s2m_t;

endpackage

`default_nettype wire

//--- verilog/wb_fetch_master.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_fetch_params.svh"

module wb_fetch_master (
	input wire logic clk,
	input wire logic rst_n,
	output rv_fetch_pkg::wb_m2s_t wb_o,
	input wire rv_fetch_pkg::wb_s2m_t wb_i,
	input wire rv_fetch_pkg::pc_cmd_t cmd,
	input wire logic pred_taken,
	input wire logic [`XLEN-1:0] pred_target,
	output logic [`XLEN-1:0] pc,
	output logic [`ILEN-1:0] inst,
	output logic accept,
	output rv_fetch_pkg::fetch_pkt_t pkt,
	output logic pkt_valid,
	input wire logic pkt_ready
);

	// *************************************************************************
	// state
	// *************************************************************************

	// idle  about to start a read at pc
	// bus   read in flight, data is kept
	// hold  packet presented downstream
	// drain read in flight after a flush, data is dropped
	typedef enum logic [1:0] {
		ST_IDLE = 2'd0,
		ST_BUS = 2'd1,
		ST_HOLD = 2'd2,
		ST_DRAIN = 2'd3
	} fetch_state_e;

	fetch_state_e state_q;
	fetch_state_e state_d;

	logic [`XLEN-1:0] pc_q;
	logic [`XLEN-1:0] pc_next;
	logic [`XLEN-1:0] adr_q;
	logic [`ILEN-1:0] inst_q;
	logic bus_active;
	logic capture;
	logic start;

	assign bus_active = (state_q == ST_BUS) || (state_q == ST_DRAIN);
	assign pkt_valid = (state_q == ST_HOLD);
	assign accept = pkt_valid && pkt_ready;

	// only a clean ack in bus gives a packet
	assign capture = (state_q == ST_BUS) && wb_i.ack && !cmd.flush;

	// pc the register will hold after this edge
	assign pc_next = cmd.load ? cmd.pc : pc_q;

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE: begin
				state_d = ST_BUS;
			end
			ST_BUS: begin
				if (cmd.flush) begin
					// ack with the flush ends the read right here
					state_d = wb_i.ack ? ST_IDLE : ST_DRAIN;
				end else if (wb_i.ack) begin
					state_d = ST_HOLD;
				end
			end
			ST_HOLD: begin
				if (cmd.flush) begin
					state_d = ST_IDLE;
				end else if (accept) begin
					state_d = ST_BUS;
				end
			end
			ST_DRAIN: begin
				if (wb_i.ack) begin
					state_d = ST_IDLE;
				end
			end
			default: begin
				state_d = ST_IDLE;
			end
		endcase
	end

	// a new read begins at this edge
	assign start = (state_d == ST_BUS) && !bus_active;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q <= ST_IDLE;
			pc_q <= `RESET_PC;
		end else begin
			state_q <= state_d;
			pc_q <= pc_next;
		end
	end

	// *************************************************************************
	// bus address and instruction capture
	// *************************************************************************

	// adr stays put through drain while pc moves on
	always_ff @(posedge clk) begin
		if (start) begin
			adr_q <= {pc_next[`XLEN-1:3], 3'b000};
		end
	end

	// pc is stable in bus, bit 2 picks the half
	always_ff @(posedge clk) begin
		if (capture) begin
			inst_q <= pc_q[2] ? wb_i.dat[63:32] : wb_i.dat[31:0];
		end
	end

	// *************************************************************************
	// outputs
	// *************************************************************************

	always_comb begin
		wb_o.cyc = bus_active;
		wb_o.stb = bus_active;
		// read only, whole word
		wb_o.we = 1'b0;
		wb_o.sel = '1;
		wb_o.adr = adr_q;
	end

	assign pc = pc_q;
	assign inst = inst_q;

	// packet built from held regs plus prediction
	always_comb begin
		pkt.pc = pc_q;
		pkt.inst = inst_q;
		pkt.pred_taken = pred_taken;
		pkt.pred_target = pred_target;
	end

endmodule

`default_nettype wire
